// ==== common/scratch_pkg.sv ====
// Shared widths, sizes and register offsets for the scratch memory subsystem.
// Memory and control space each cover 4 KB of the 8 KB bus window.
// Addresses are byte addresses; bits 1:0 are ignored everywhere.

`default_nettype none

package scratch_pkg;

    // data path
    localparam int XLEN           = 32;
    localparam int BYTES_PER_WORD = XLEN / 8;

    // scratch size
    localparam int MEM_KB      = 4;
    localparam int MEM_LINES   = (MEM_KB * 1024) / BYTES_PER_WORD;
    localparam int LINE_ADDR_W = $clog2(MEM_LINES);

    // bus window, truncated to 13 bits
    localparam int BUS_ADDR_W   = 13;
    localparam int CTRL_SEL_BIT = 12;

    // control register word offsets
    localparam logic [LINE_ADDR_W-1:0] REG_RESET_OFS = 'd0;
    localparam logic [LINE_ADDR_W-1:0] REG_MODE_OFS  = 'd1;

    // arbitration policy
    localparam logic MODE_FIXED       = 1'b0;
    localparam logic MODE_ROUND_ROBIN = 1'b1;

endpackage

`default_nettype wire

// ==== byte_en_bram/byte_en_bram.sv ====
// Dual-port word memory, port A read only, port B read/write with byte enables.
// Both ports register read data one edge after the enable and hold it after.
// Port B reads return the old word on a write (read-first). No initial image.

`default_nettype none

module byte_en_bram (
    input  wire logic                                   clk,

    // port A, instruction fetch
    input  wire logic                                   a_en,
    input  wire logic [scratch_pkg::LINE_ADDR_W-1:0]    a_addr,
    output logic      [scratch_pkg::XLEN-1:0]           a_rdata,

    // port B, data
    input  wire logic                                   b_en,
    input  wire logic                                   b_we,
    input  wire logic [scratch_pkg::BYTES_PER_WORD-1:0] b_be,
    input  wire logic [scratch_pkg::LINE_ADDR_W-1:0]    b_addr,
    input  wire logic [scratch_pkg::XLEN-1:0]           b_wdata,
    output logic      [scratch_pkg::XLEN-1:0]           b_rdata
);

    logic [scratch_pkg::XLEN-1:0] mem [scratch_pkg::MEM_LINES];

    // port A read
    always_ff @(posedge clk) begin
        if (a_en) begin
            a_rdata <= mem[a_addr];
        end
    end

    // port B byte-merged write
    always_ff @(posedge clk) begin
        if (b_en && b_we) begin
            for (int i = 0; i < scratch_pkg::BYTES_PER_WORD; i++) begin
                if (b_be[i]) begin
                    mem[b_addr][i*8 +: 8] <= b_wdata[i*8 +: 8];
                end
            end
        end
    end

    // port B read
    always_ff @(posedge clk) begin
        if (b_en) begin
            b_rdata <= mem[b_addr];
        end
    end

endmodule

`default_nettype wire

// ==== mem_port_arbiter/mem_port_arbiter.sv ====
// Shares memory port B between the core data port and the bus-side requester.
// One access in flight; uncontested request to done is 2 cycles.
// Requesters hold req and payload until done and drop req at the done edge.
// Addresses here are word indices.

`default_nettype none

module mem_port_arbiter (
    input  wire logic                                   clk,
    input  wire logic                                   rst,
    input  wire logic                                   arb_mode,

    // core data requester
    input  wire logic                                   core_req,
    input  wire logic                                   core_we,
    input  wire logic [scratch_pkg::BYTES_PER_WORD-1:0] core_be,
    input  wire logic [scratch_pkg::LINE_ADDR_W-1:0]    core_addr,
    input  wire logic [scratch_pkg::XLEN-1:0]           core_wdata,
    output logic                                        core_done,
    output logic      [scratch_pkg::XLEN-1:0]           core_rdata,

    // bus-side requester
    input  wire logic                                   mem_req,
    input  wire logic                                   mem_we,
    input  wire logic [scratch_pkg::BYTES_PER_WORD-1:0] mem_be,
    input  wire logic [scratch_pkg::LINE_ADDR_W-1:0]    mem_addr,
    input  wire logic [scratch_pkg::XLEN-1:0]           mem_wdata,
    output logic                                        mem_done,
    output logic      [scratch_pkg::XLEN-1:0]           mem_rdata,

    // memory port B
    output logic                                        b_en,
    output logic                                        b_we,
    output logic      [scratch_pkg::BYTES_PER_WORD-1:0] b_be,
    output logic      [scratch_pkg::LINE_ADDR_W-1:0]    b_addr,
    output logic      [scratch_pkg::XLEN-1:0]           b_wdata,
    input  wire logic [scratch_pkg::XLEN-1:0]           b_rdata
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ISSUE,
        ST_RESPOND
    } arb_state_t;

    arb_state_t state;
    logic       last_bus;   // also owner of the access in flight
    logic       grant_core;
    logic       grant_bus;

    // bus wins when alone, or in round robin when the core went last
    always_comb begin
        grant_bus = mem_req &&
                    (!core_req ||
                     (arb_mode == scratch_pkg::MODE_ROUND_ROBIN && !last_bus));
        grant_core = core_req && !grant_bus;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= ST_IDLE;
            last_bus <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (grant_core || grant_bus) begin
                        state    <= ST_ISSUE;
                        last_bus <= grant_bus;
                    end
                end
                ST_ISSUE:   state <= ST_RESPOND;
                ST_RESPOND: state <= ST_IDLE;
                default:    state <= ST_IDLE;
            endcase
        end
    end

    // latch winner payload, held stable through issue
    always_ff @(posedge clk) begin
        if (state == ST_IDLE) begin
            if (grant_bus) begin
                b_we    <= mem_we;
                b_be    <= mem_be;
                b_addr  <= mem_addr;
                b_wdata <= mem_wdata;
            end else if (grant_core) begin
                b_we    <= core_we;
                b_be    <= core_be;
                b_addr  <= core_addr;
                b_wdata <= core_wdata;
            end
        end
    end

    assign b_en = (state == ST_ISSUE);

    // done to whoever owns the access
    assign core_done  = (state == ST_RESPOND) && !last_bus;
    assign mem_done   = (state == ST_RESPOND) && last_bus;
    assign core_rdata = b_rdata;
    assign mem_rdata  = b_rdata;

endmodule

`default_nettype wire

// ==== design/bus_port.sv ====
// Bus-side decode: bit 12 clear goes to memory, set goes to control registers.
// Control access: done 1 cycle after request. Memory access: 3 cycles uncontested.
// The bus holds req and payload until done and drops req at the done edge.

`default_nettype none

module bus_port (
    input  wire logic                                   clk,
    input  wire logic                                   rst,

    // bus side
    input  wire logic                                   bus_req,
    input  wire logic                                   bus_we,
    input  wire logic [scratch_pkg::BYTES_PER_WORD-1:0] bus_be,
    input  wire logic [scratch_pkg::BUS_ADDR_W-1:0]     bus_addr,
    input  wire logic [scratch_pkg::XLEN-1:0]           bus_wdata,
    output logic                                        bus_done,
    output logic      [scratch_pkg::XLEN-1:0]           bus_rdata,

    // toward the arbiter
    output logic                                        mem_req,
    output logic                                        mem_we,
    output logic      [scratch_pkg::BYTES_PER_WORD-1:0] mem_be,
    output logic      [scratch_pkg::LINE_ADDR_W-1:0]    mem_addr,
    output logic      [scratch_pkg::XLEN-1:0]           mem_wdata,
    input  wire logic                                   mem_done,
    input  wire logic [scratch_pkg::XLEN-1:0]           mem_rdata,

    // toward the control registers
    output logic                                        reg_wr,
    output logic                                        reg_rd,
    output logic      [scratch_pkg::LINE_ADDR_W-1:0]    reg_idx,
    output logic                                        reg_wdata,
    input  wire logic [scratch_pkg::XLEN-1:0]           reg_rdata
);

    logic sel_ctrl;
    logic active;       // request not yet answered
    logic ctrl_q;       // space of the last access, steers read data
    logic [scratch_pkg::XLEN-1:0] mem_rdata_q;

    assign sel_ctrl = bus_addr[scratch_pkg::CTRL_SEL_BIT];
    // req is still high in the done cycle, so mask it there
    assign active   = bus_req && !bus_done;

    // control space, only bit 0 of a register is writable
    assign reg_wr    = active && sel_ctrl && bus_we && bus_be[0];
    assign reg_rd    = active && sel_ctrl && !bus_we;
    assign reg_idx   = bus_addr[scratch_pkg::CTRL_SEL_BIT-1:2];
    assign reg_wdata = bus_wdata[0];

    // memory space
    assign mem_req   = active && !sel_ctrl;
    assign mem_we    = bus_we;
    assign mem_be    = bus_be;
    assign mem_addr  = bus_addr[scratch_pkg::CTRL_SEL_BIT-1:2];
    assign mem_wdata = bus_wdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            bus_done <= 1'b0;
        end else begin
            bus_done <= (active && sel_ctrl) || mem_done;
        end
    end

    always_ff @(posedge clk) begin
        if (active) begin
            ctrl_q <= sel_ctrl;
        end
        if (mem_done) begin
            mem_rdata_q <= mem_rdata;
        end
    end

    assign bus_rdata = ctrl_q ? reg_rdata : mem_rdata_q;

endmodule

`default_nettype wire

// ==== design/ctrl_regs.sv ====
// Two one-bit control registers: core reset hold and arbitration mode.
// Writes land at the request edge; reads return the bit in bit 0, registered.
// Unmapped offsets read as zero and ignore writes.

`default_nettype none

module ctrl_regs (
    input  wire logic                                clk,
    input  wire logic                                rst,
    input  wire logic                                reg_wr,
    input  wire logic                                reg_rd,
    input  wire logic [scratch_pkg::LINE_ADDR_W-1:0] reg_idx,
    input  wire logic                                reg_wdata,
    output logic      [scratch_pkg::XLEN-1:0]        reg_rdata,
    output logic                                     arb_mode,
    output logic                                     core_rst
);

    // core held in reset until software releases it
    always_ff @(posedge clk) begin
        if (rst) begin
            core_rst <= 1'b1;
            arb_mode <= scratch_pkg::MODE_FIXED;
        end else if (reg_wr) begin
            case (reg_idx)
                scratch_pkg::REG_RESET_OFS: core_rst <= reg_wdata;
                scratch_pkg::REG_MODE_OFS:  arb_mode <= reg_wdata;
                default: ;
            endcase
        end
    end

    // read data only updates on a read
    always_ff @(posedge clk) begin
        if (reg_rd) begin
            reg_rdata <= '0;
            case (reg_idx)
                scratch_pkg::REG_RESET_OFS: reg_rdata[0] <= core_rst;
                scratch_pkg::REG_MODE_OFS:  reg_rdata[0] <= arb_mode;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/scratch_mem_subsystem.sv ====
// Scratch memory subsystem: fetch on port A, core data and bus share port B.
// fetch_addr and core_addr are byte addresses into the 4 KB scratch.
// Bus window is 8 KB; bus_addr bit 12 selects the control registers.
// core_rst comes out of reset high and is cleared by a bus write.

`default_nettype none

module scratch_mem_subsystem (
    input  wire logic                                   clk,
    input  wire logic                                   rst,

    // instruction fetch
    input  wire logic                                   fetch_en,
    input  wire logic [scratch_pkg::LINE_ADDR_W+1:0]    fetch_addr,
    output logic      [scratch_pkg::XLEN-1:0]           fetch_data,

    // core data port
    input  wire logic                                   core_req,
    input  wire logic                                   core_we,
    input  wire logic [scratch_pkg::BYTES_PER_WORD-1:0] core_be,
    input  wire logic [scratch_pkg::LINE_ADDR_W+1:0]    core_addr,
    input  wire logic [scratch_pkg::XLEN-1:0]           core_wdata,
    output logic                                        core_done,
    output logic      [scratch_pkg::XLEN-1:0]           core_rdata,

    // memory-mapped bus port
    input  wire logic                                   bus_req,
    input  wire logic                                   bus_we,
    input  wire logic [scratch_pkg::BYTES_PER_WORD-1:0] bus_be,
    input  wire logic [scratch_pkg::BUS_ADDR_W-1:0]     bus_addr,
    input  wire logic [scratch_pkg::XLEN-1:0]           bus_wdata,
    output logic                                        bus_done,
    output logic      [scratch_pkg::XLEN-1:0]           bus_rdata,

    output logic                                        core_rst
);

    // bus_port to arbiter
    logic                                   mem_req;
    logic                                   mem_we;
    logic [scratch_pkg::BYTES_PER_WORD-1:0] mem_be;
    logic [scratch_pkg::LINE_ADDR_W-1:0]    mem_addr;
    logic [scratch_pkg::XLEN-1:0]           mem_wdata;
    logic                                   mem_done;
    logic [scratch_pkg::XLEN-1:0]           mem_rdata;

    // bus_port to control registers
    logic                                   reg_wr;
    logic                                   reg_rd;
    logic [scratch_pkg::LINE_ADDR_W-1:0]    reg_idx;
    logic                                   reg_wdata;
    logic [scratch_pkg::XLEN-1:0]           reg_rdata;
    logic                                   arb_mode;

    // arbiter to memory port B
    logic                                   b_en;
    logic                                   b_we;
    logic [scratch_pkg::BYTES_PER_WORD-1:0] b_be;
    logic [scratch_pkg::LINE_ADDR_W-1:0]    b_addr;
    logic [scratch_pkg::XLEN-1:0]           b_wdata;
    logic [scratch_pkg::XLEN-1:0]           b_rdata;

    byte_en_bram bram_inst (
        .clk     (clk),
        .a_en    (fetch_en),
        .a_addr  (fetch_addr[scratch_pkg::LINE_ADDR_W+1:2]),
        .a_rdata (fetch_data),
        .b_en    (b_en),
        .b_we    (b_we),
        .b_be    (b_be),
        .b_addr  (b_addr),
        .b_wdata (b_wdata),
        .b_rdata (b_rdata)
    );

    mem_port_arbiter arbiter_inst (
        .clk        (clk),
        .rst        (rst),
        .arb_mode   (arb_mode),
        .core_req   (core_req),
        .core_we    (core_we),
        .core_be    (core_be),
        .core_addr  (core_addr[scratch_pkg::LINE_ADDR_W+1:2]),
        .core_wdata (core_wdata),
        .core_done  (core_done),
        .core_rdata (core_rdata),
        .mem_req    (mem_req),
        .mem_we     (mem_we),
        .mem_be     (mem_be),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_done   (mem_done),
        .mem_rdata  (mem_rdata),
        .b_en       (b_en),
        .b_we       (b_we),
        .b_be       (b_be),
        .b_addr     (b_addr),
        .b_wdata    (b_wdata),
        .b_rdata    (b_rdata)
    );

    bus_port bus_port_inst (
        .clk       (clk),
        .rst       (rst),
        .bus_req   (bus_req),
        .bus_we    (bus_we),
        .bus_be    (bus_be),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .bus_done  (bus_done),
        .bus_rdata (bus_rdata),
        .mem_req   (mem_req),
        .mem_we    (mem_we),
        .mem_be    (mem_be),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_done  (mem_done),
        .mem_rdata (mem_rdata),
        .reg_wr    (reg_wr),
        .reg_rd    (reg_rd),
        .reg_idx   (reg_idx),
        .reg_wdata (reg_wdata),
        .reg_rdata (reg_rdata)
    );

    ctrl_regs ctrl_regs_inst (
        .clk       (clk),
        .rst       (rst),
        .reg_wr    (reg_wr),
        .reg_rd    (reg_rd),
        .reg_idx   (reg_idx),
        .reg_wdata (reg_wdata),
        .reg_rdata (reg_rdata),
        .arb_mode  (arb_mode),
        .core_rst  (core_rst)
    );

endmodule

`default_nettype wire

// ==== bench/arbiter_checker.sv ====
// Assertions on the port B arbiter, bound into mem_port_arbiter.
// Checks are disabled while rst is high, except the post-reset check.

`default_nettype none

module arbiter_checker (
    input wire logic clk,
    input wire logic rst,
    input wire logic core_req,
    input wire logic mem_req,
    input wire logic core_done,
    input wire logic mem_done,
    input wire logic b_en
);

    int unsigned fail_count = 0;

    // one owner per response
    one_done: assert property (@(posedge clk) disable iff (rst) !(core_done && mem_done))
        else begin
            fail_count++;
            $error("core_done and mem_done high together");
        end

    // done is a single-cycle pulse
    core_pulse: assert property (@(posedge clk) disable iff (rst) core_done |=> !core_done)
        else begin
            fail_count++;
            $error("core_done high for two cycles");
        end

    mem_pulse: assert property (@(posedge clk) disable iff (rst) mem_done |=> !mem_done)
        else begin
            fail_count++;
            $error("mem_done high for two cycles");
        end

    // port B only opens for a request seen the cycle before
    en_after_req: assert property (@(posedge clk) disable iff (rst)
                                   b_en |-> $past(core_req || mem_req))
        else begin
            fail_count++;
            $error("b_en high without a pending request");
        end

    quiet_after_reset: assert property (@(posedge clk) rst |=> !core_done && !mem_done)
        else begin
            fail_count++;
            $error("done high in the cycle after reset");
        end

endmodule

bind mem_port_arbiter arbiter_checker arbiter_checker_inst (
    .clk       (clk),
    .rst       (rst),
    .core_req  (core_req),
    .mem_req   (mem_req),
    .core_done (core_done),
    .mem_done  (mem_done),
    .b_en      (b_en)
);

`default_nettype wire

// ==== bench/scratch_mem_tb.sv ====
// Testbench for the scratch memory subsystem.
// Reads bench/scratch_tests.mem, so the simulator must run from the project root.
// Inputs change on rising edges, outputs are sampled on falling edges.

`default_nettype none

module scratch_mem_tb;

    localparam int TIMEOUT_CYCLES = 40;
    localparam int OP_FIELDS      = 6;
    localparam int MAX_OPS        = 32;
    localparam int SWEEP_LEN      = 12;

    logic        clk;
    logic        rst;
    logic        fetch_en;
    logic [11:0] fetch_addr;
    logic [31:0] fetch_data;
    logic        core_req;
    logic        core_we;
    logic [3:0]  core_be;
    logic [11:0] core_addr;
    logic [31:0] core_wdata;
    logic        core_done;
    logic [31:0] core_rdata;
    logic        bus_req;
    logic        bus_we;
    logic [3:0]  bus_be;
    logic [12:0] bus_addr;
    logic [31:0] bus_wdata;
    logic        bus_done;
    logic [31:0] bus_rdata;
    logic        core_rst;

    logic [31:0] tests [OP_FIELDS*MAX_OPS];
    logic [31:0] ref_mem [scratch_pkg::MEM_LINES];
    logic [9:0]  sweep_idx [SWEEP_LEN];
    logic [31:0] lcg_state;
    int          cycle_cnt = 0;

    scratch_mem_subsystem scratch_mem_subsystem_inst (
        .clk(clk), .rst(rst),
        .fetch_en(fetch_en), .fetch_addr(fetch_addr), .fetch_data(fetch_data),
        .core_req(core_req), .core_we(core_we), .core_be(core_be), .core_addr(core_addr),
        .core_wdata(core_wdata), .core_done(core_done), .core_rdata(core_rdata),
        .bus_req(bus_req), .bus_we(bus_we), .bus_be(bus_be), .bus_addr(bus_addr),
        .bus_wdata(bus_wdata), .bus_done(bus_done), .bus_rdata(bus_rdata),
        .core_rst(core_rst)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    task automatic stop_with_error(input string msg);
        $display("%s at time %0t", msg, $time);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] time %0t %s: got %h, expected %h", $time, name, got, exp);
            $display("*** TEST FAILED ***");
            $fatal(1, "value mismatch");
        end
    endtask

    // an assertion in the bound checker ends the run at once
    always @(negedge clk) begin
        if (scratch_mem_subsystem_inst.arbiter_inst.arbiter_checker_inst.fail_count != 0) begin
            stop_with_error("an arbiter assertion failed");
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic draw_random(output logic [31:0] value);
        lcg_state = lcg_next(lcg_state);
        value = lcg_state;
    endtask

    // byte merge, as port B does it
    task automatic ref_write(input logic [9:0] idx, input logic [3:0] be,
                             input logic [31:0] data);
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                ref_mem[idx][b*8 +: 8] = data[b*8 +: 8];
            end
        end
    endtask

    task automatic core_access(input logic we, input logic [3:0] be, input logic [11:0] addr,
                               input logic [31:0] wdata, output logic [31:0] rdata,
                               output int lat, output int done_at);
        int waited;
        @(posedge clk);
        core_req   <= 1'b1;
        core_we    <= we;
        core_be    <= be;
        core_addr  <= addr;
        core_wdata <= wdata;
        waited = 0;
        @(negedge clk);
        while (!core_done) begin
            waited++;
            if (waited > TIMEOUT_CYCLES) begin
                stop_with_error("timeout while waiting for core_done");
            end
            @(negedge clk);
        end
        lat     = waited;
        rdata   = core_rdata;
        done_at = cycle_cnt;
        @(posedge clk);
        core_req <= 1'b0;
    endtask

    task automatic bus_access(input logic we, input logic [3:0] be, input logic [12:0] addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output int lat, output int done_at);
        int waited;
        @(posedge clk);
        bus_req   <= 1'b1;
        bus_we    <= we;
        bus_be    <= be;
        bus_addr  <= addr;
        bus_wdata <= wdata;
        waited = 0;
        @(negedge clk);
        while (!bus_done) begin
            waited++;
            if (waited > TIMEOUT_CYCLES) begin
                stop_with_error("timeout while waiting for bus_done");
            end
            @(negedge clk);
        end
        lat     = waited;
        rdata   = bus_rdata;
        done_at = cycle_cnt;
        @(posedge clk);
        bus_req <= 1'b0;
    endtask

    // data is valid after the edge that samples fetch_en
    task automatic fetch_word(input logic [11:0] addr, output logic [31:0] data);
        @(posedge clk);
        fetch_en   <= 1'b1;
        fetch_addr <= addr;
        @(posedge clk);
        fetch_en <= 1'b0;
        @(negedge clk);
        data = fetch_data;
    endtask

    task automatic run_file_ops();
        logic [31:0] kind;
        logic [31:0] port;
        logic [31:0] addr;
        logic [31:0] be;
        logic [31:0] wdata;
        logic [31:0] exp_data;
        logic [31:0] rdata;
        int          lat;
        int          done_at;
        int          exp_lat;
        for (int i = 0; i < MAX_OPS; i++) begin
            kind     = tests[i*OP_FIELDS];
            port     = tests[i*OP_FIELDS+1];
            addr     = tests[i*OP_FIELDS+2];
            be       = tests[i*OP_FIELDS+3];
            wdata    = tests[i*OP_FIELDS+4];
            exp_data = tests[i*OP_FIELDS+5];
            if (kind == 32'hff) begin
                break;
            end
            case (kind)
                32'h0, 32'h1: begin
                    if (port == 0) begin
                        core_access(kind == 0, be[3:0], addr[11:0], wdata, rdata, lat, done_at);
                        exp_lat = 2;
                    end else begin
                        bus_access(kind == 0, be[3:0], addr[12:0], wdata, rdata, lat, done_at);
                        // control space answers in one cycle, memory in three
                        exp_lat = addr[12] ? 1 : 3;
                    end
                    check_value("access latency", lat, exp_lat);
                    if (kind == 0 && !(port == 1 && addr[12])) begin
                        ref_write(addr[11:2], be[3:0], wdata);
                    end
                    if (kind == 1 && port == 0) begin
                        check_value("core_rdata", rdata, exp_data);
                    end
                    if (kind == 1 && port == 1) begin
                        check_value("bus_rdata", rdata, exp_data);
                    end
                end
                32'h2: begin
                    fetch_word(addr[11:0], rdata);
                    check_value("fetch_data", rdata, exp_data);
                end
                default: stop_with_error("unknown operation kind in the test file");
            endcase
        end
    endtask

    initial begin
        logic [31:0] rd_core;
        logic [31:0] rd_bus;
        logic [31:0] data_a;
        logic [31:0] data_b;
        logic [31:0] rnd;
        int          lat_core;
        int          lat_bus;
        int          t_core;
        int          t_bus;
        logic        last_bus;
        logic        bus_first;
        clk        = 1'b0;
        rst        = 1'b1;
        fetch_en   = 1'b0;
        fetch_addr = '0;
        core_req   = 1'b0;
        core_we    = 1'b0;
        core_be    = '0;
        core_addr  = '0;
        core_wdata = '0;
        bus_req    = 1'b0;
        bus_we     = 1'b0;
        bus_be     = '0;
        bus_addr   = '0;
        bus_wdata  = '0;
        lcg_state  = 32'd66;
        $readmemh("bench/scratch_tests.mem", tests);
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_value("core_rst", core_rst, 1);
        check_value("core_done", core_done, 0);
        check_value("bus_done", bus_done, 0);

        run_file_ops();

        // fixed mode, core wins a tie
        draw_random(data_a);
        draw_random(data_b);
        fork
            core_access(1'b1, 4'hf, 12'h100, data_a, rd_core, lat_core, t_core);
            bus_access(1'b1, 4'hf, 13'h0200, data_b, rd_bus, lat_bus, t_bus);
        join
        ref_write(10'h040, 4'hf, data_a);
        ref_write(10'h080, 4'hf, data_b);
        check_value("core_done first on write tie", t_core < t_bus, 1);
        fork
            core_access(1'b0, 4'hf, 12'h100, 32'h0, rd_core, lat_core, t_core);
            bus_access(1'b0, 4'hf, 13'h0200, 32'h0, rd_bus, lat_bus, t_bus);
        join
        check_value("core_done first on read tie", t_core < t_bus, 1);
        check_value("core_rdata", rd_core, ref_mem[10'h040]);
        check_value("bus_rdata", rd_bus, ref_mem[10'h080]);
        last_bus  = 1'b1;
        bus_first = 1'b0;

        // round robin, the side not granted last wins a tie
        bus_access(1'b1, 4'hf, 13'h1004, 32'(scratch_pkg::MODE_ROUND_ROBIN),
                   rd_bus, lat_bus, t_bus);
        for (int r = 0; r < 4; r++) begin
            // lone access by the last winner hands the turn to the other side
            if (r > 0 && bus_first) begin
                bus_access(1'b0, 4'hf, 13'h0200, 32'h0, rd_bus, lat_bus, t_bus);
                last_bus = 1'b1;
            end else if (r > 0) begin
                core_access(1'b0, 4'hf, 12'h100, 32'h0, rd_core, lat_core, t_core);
                last_bus = 1'b0;
            end
            bus_first = !last_bus;
            fork
                core_access(1'b0, 4'hf, 12'h100, 32'h0, rd_core, lat_core, t_core);
                bus_access(1'b0, 4'hf, 13'h0200, 32'h0, rd_bus, lat_bus, t_bus);
            join
            check_value("bus granted first", t_bus < t_core, bus_first);
            check_value("core_rdata", rd_core, ref_mem[10'h040]);
            check_value("bus_rdata", rd_bus, ref_mem[10'h080]);
            last_bus = !bus_first;
        end

        // release the core, then random sweep
        bus_access(1'b1, 4'hf, 13'h1000, 32'h0, rd_bus, lat_bus, t_bus);
        check_value("core_rst", core_rst, 0);
        for (int i = 0; i < SWEEP_LEN; i++) begin
            draw_random(rnd);
            sweep_idx[i] = {2'b01, rnd[7:0]};
            draw_random(data_a);
            if (i % 2 == 0) begin
                core_access(1'b1, 4'hf, {sweep_idx[i], 2'b00}, data_a, rd_core, lat_core, t_core);
            end else begin
                bus_access(1'b1, 4'hf, {1'b0, sweep_idx[i], 2'b00}, data_a, rd_bus, lat_bus,
                           t_bus);
            end
            ref_write(sweep_idx[i], 4'hf, data_a);
        end
        for (int i = 0; i < SWEEP_LEN; i++) begin
            core_access(1'b0, 4'hf, {sweep_idx[i], 2'b00}, 32'h0, rd_core, lat_core, t_core);
            check_value("core_rdata", rd_core, ref_mem[sweep_idx[i]]);
            fetch_word({sweep_idx[i], 2'b00}, rd_core);
            check_value("fetch_data", rd_core, ref_mem[sweep_idx[i]]);
        end

        repeat (2) @(posedge clk);
        if (scratch_mem_subsystem_inst.arbiter_inst.arbiter_checker_inst.fail_count != 0) begin
            $display("arbiter assertion failures were reported");
            $display("*** TEST FAILED ***");
            $fatal(1, "simulation stopped");
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== bench/scratch_tests.mem ====
// kind port addr be wdata expected  (kind: 0 write, 1 read, 2 fetch, ff end)
// port: 0 core, 1 bus; addr is a byte address, bit 12 set is control space
1 1 1000 f 00000000 00000001
1 1 1004 f 00000000 00000000
1 1 1008 f 00000000 00000000
0 1 0040 f cafef00d 00000000
2 0 0040 0 00000000 cafef00d
0 0 0080 f 11223344 00000000
0 0 0080 1 000000aa 00000000
0 0 0080 c 5566ffff 00000000
1 0 0080 f 00000000 556633aa
2 0 0080 0 00000000 556633aa
0 1 00c0 f deadbeef 00000000
0 0 00c0 6 00123400 00000000
1 0 00c0 f 00000000 de1234ef
1 1 00c0 f 00000000 de1234ef
0 0 0084 f 00000000 00000000
0 1 0084 9 a1b2c3d4 00000000
1 0 0084 f 00000000 a10000d4
ff 0 0 0 0 0

// ==== all.f ====
common/scratch_pkg.sv
byte_en_bram/byte_en_bram.sv
mem_port_arbiter/mem_port_arbiter.sv
design/bus_port.sv
design/ctrl_regs.sv
design/scratch_mem_subsystem.sv
bench/arbiter_checker.sv
bench/scratch_mem_tb.sv

// ==== Bender.yml ====
package:
  name: scratch_mem_subsystem

sources:
  # design, in compile order
  - files:
      - common/scratch_pkg.sv
      - byte_en_bram/byte_en_bram.sv
      - mem_port_arbiter/mem_port_arbiter.sv
      - design/bus_port.sv
      - design/ctrl_regs.sv
      - design/scratch_mem_subsystem.sv
  # testbench, top module scratch_mem_tb
  - target: test
    files:
      - bench/arbiter_checker.sv
      - bench/scratch_mem_tb.sv
